// File: Bender.yml
package:
  name: obs_support

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/obs_support_pkg.sv
      - logic/obi_obs_if.sv
      - logic/obi_phase_tracker.sv
      - logic/trap_req_tracker.sv
      - logic/obs_support_top.sv

  - target: test
    include_dirs:
      - logic
    files:
      - dv/tb_obs_support.sv

// File: dv/tb_obs_support.sv
/*
  Testbench for the bus observer top level
  Clock, reset, directed and random stimulus, reference model,
  concurrent assertions against the model, reporting and watchdog
*/

`timescale 1ns/100ps
`default_nettype none

`include "obs_support_defines.svh"

module tb_obs_support;

  localparam int CLK_PERIOD     = 8;
  localparam int SEED           = 53656;
  // Cycle budget per test, used by the watchdog
  localparam int RESET_CYCLES   = 8;
  localparam int STALL_CYCLES   = 2 * `OBS_NUM_BUS * 10;
  localparam int TRAFFIC_CYCLES = 200;
  localparam int TRAP_CYCLES    = 60;
  localparam int TOTAL_CYCLES   = RESET_CYCLES + STALL_CYCLES + TRAFFIC_CYCLES + TRAP_CYCLES;
  localparam int MARGIN_CYCLES  = 100;

  // --------------------------------------------------------------------------
  // DUT signals
  // --------------------------------------------------------------------------
  // Starts high so the first edge is a falling edge
  logic clk_i = 1'b1;
  logic rst_ni;
  // Bit 0 instruction bus, bit 1 data bus
  logic [`OBS_NUM_BUS-1:0] req;
  logic [`OBS_NUM_BUS-1:0] gnt;
  logic [`OBS_NUM_BUS-1:0] rvalid;
  logic [`OBS_NUM_BUS-1:0] rready;
  logic pc_set;
  obs_support_pkg::pc_mux_e pc_mux;
  logic rvfi_valid;
  logic instr_addr_cont;
  logic instr_resp_cont;
  logic [`OBS_CNT_W-1:0] instr_cnt;
  logic data_addr_cont;
  logic data_resp_cont;
  logic [`OBS_CNT_W-1:0] data_cnt;
  logic req_after_exc;

  int err_cnt = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int err_at_start = 0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  obs_support_top u_obs_support_top (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .instr_req_i          (req[0]),
    .instr_gnt_i          (gnt[0]),
    .instr_rvalid_i       (rvalid[0]),
    .instr_rready_i       (rready[0]),
    .data_req_i           (req[1]),
    .data_gnt_i           (gnt[1]),
    .data_rvalid_i        (rvalid[1]),
    .data_rready_i        (rready[1]),
    .ctrl_pc_set_i        (pc_set),
    .ctrl_pc_mux_i        (pc_mux),
    .rvfi_valid_i         (rvfi_valid),
    .instr_addr_ph_cont_o (instr_addr_cont),
    .instr_resp_ph_cont_o (instr_resp_cont),
    .instr_addr_ph_cnt_o  (instr_cnt),
    .data_addr_ph_cont_o  (data_addr_cont),
    .data_resp_ph_cont_o  (data_resp_cont),
    .data_addr_ph_cnt_o   (data_cnt),
    .req_after_exc_o      (req_after_exc)
  );

  // --------------------------------------------------------------------------
  // Reference model, one cycle behind the inputs
  // --------------------------------------------------------------------------
  logic m_addr_cont [`OBS_NUM_BUS];
  logic m_resp_cont [`OBS_NUM_BUS];
  logic [`OBS_CNT_W-1:0] m_cnt [`OBS_NUM_BUS];
  logic m_gnt_q;
  logic m_exc_active;
  logic m_flag;
  logic m_trap;
  // Low during reset and on the first edge after release
  logic rst_q;

  // Only exception and bus-error traps open the window
  assign m_trap = pc_set && (pc_mux == obs_support_pkg::PC_TRAP_EXC ||
                             pc_mux == obs_support_pkg::PC_TRAP_DBE);

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int b = 0; b < `OBS_NUM_BUS; b++) begin
        m_addr_cont[b] <= 1'b0;
        m_resp_cont[b] <= 1'b0;
        m_cnt[b]       <= '0;
      end
      m_gnt_q      <= 1'b0;
      m_exc_active <= 1'b0;
      m_flag       <= 1'b0;
      rst_q        <= 1'b0;
    end else begin
      rst_q <= 1'b1;
      for (int b = 0; b < `OBS_NUM_BUS; b++) begin
        m_addr_cont[b] <= req[b] && !gnt[b];
        m_resp_cont[b] <= rvalid[b] && !rready[b];
        // {address phase, response phase}
        case ({req[b] && gnt[b], rvalid[b] && rready[b]})
          2'b10: m_cnt[b] <= m_cnt[b] + 1'b1;
          2'b01: if (m_cnt[b] != '0) m_cnt[b] <= m_cnt[b] - 1'b1;
          default: ;
        endcase
      end
      m_gnt_q <= gnt[1];
      if (m_trap) begin
        m_exc_active <= 1'b1;
        if (req[1] && m_gnt_q) m_flag <= 1'b1;
      end else if (rvfi_valid) begin
        m_exc_active <= 1'b0;
        m_flag       <= 1'b0;
      end else if (m_exc_active && req[1] && m_gnt_q) begin
        m_flag <= 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Assertions
  // --------------------------------------------------------------------------
  task automatic report_mismatch(input string name, input longint got, input longint exp);
    $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    err_cnt++;
  endtask

  assert property (@(posedge clk_i) (!rst_ni || !rst_q) |->
                   (!instr_addr_cont && !instr_resp_cont && instr_cnt == '0 &&
                    !data_addr_cont && !data_resp_cont && data_cnt == '0 && !req_after_exc))
    else begin
      $display("Error at %0t: outputs were not at reset values around reset", $time);
      err_cnt++;
    end

  assert property (@(posedge clk_i) instr_addr_cont == m_addr_cont[0])
    else report_mismatch("instr_addr_ph_cont_o", $sampled(instr_addr_cont),
                         $sampled(m_addr_cont[0]));
  assert property (@(posedge clk_i) instr_resp_cont == m_resp_cont[0])
    else report_mismatch("instr_resp_ph_cont_o", $sampled(instr_resp_cont),
                         $sampled(m_resp_cont[0]));
  assert property (@(posedge clk_i) instr_cnt == m_cnt[0])
    else report_mismatch("instr_addr_ph_cnt_o", $sampled(instr_cnt),
                         $sampled(m_cnt[0]));
  assert property (@(posedge clk_i) data_addr_cont == m_addr_cont[1])
    else report_mismatch("data_addr_ph_cont_o", $sampled(data_addr_cont),
                         $sampled(m_addr_cont[1]));
  assert property (@(posedge clk_i) data_resp_cont == m_resp_cont[1])
    else report_mismatch("data_resp_ph_cont_o", $sampled(data_resp_cont),
                         $sampled(m_resp_cont[1]));
  assert property (@(posedge clk_i) data_cnt == m_cnt[1])
    else report_mismatch("data_addr_ph_cnt_o", $sampled(data_cnt),
                         $sampled(m_cnt[1]));
  assert property (@(posedge clk_i) req_after_exc == m_flag)
    else report_mismatch("req_after_exc_o", $sampled(req_after_exc),
                         $sampled(m_flag));

  // --------------------------------------------------------------------------
  // Stimulus helpers, inputs change on falling edges only
  // --------------------------------------------------------------------------
  task automatic step();
    @(negedge clk_i);
  endtask

  task automatic drive_idle();
    req        = '0;
    gnt        = '0;
    rvalid     = '0;
    rready     = '0;
    pc_set     = 1'b0;
    pc_mux     = obs_support_pkg::PC_BOOT;
    rvfi_valid = 1'b0;
  endtask

  // Settle two cycles so the last outputs are checked, then report
  task automatic close_test(input string name);
    drive_idle();
    step();
    step();
    if (err_cnt == err_at_start) begin
      $display("Test %s: passed", name);
      tests_passed++;
    end else begin
      $display("Test %s: failed with %0d errors", name, err_cnt - err_at_start);
      tests_failed++;
    end
    err_at_start = err_cnt;
  endtask

  task automatic retire();
    rvfi_valid = 1'b1;
    step();
    rvfi_valid = 1'b0;
  endtask

  // Held req, then a grant
  task automatic stall_address(input int b);
    req[b] = 1'b1;
    gnt[b] = 1'b0;
    repeat ($urandom_range(1, 6)) step();
    gnt[b] = 1'b1;
    step();
    drive_idle();
    step();
  endtask

  // Held rvalid, then rready
  task automatic stall_response(input int b);
    rvalid[b] = 1'b1;
    rready[b] = 1'b0;
    repeat ($urandom_range(1, 6)) step();
    rready[b] = 1'b1;
    step();
    drive_idle();
    step();
  endtask

  task automatic run_traffic(input int cycles);
    repeat (cycles) begin
      for (int b = 0; b < `OBS_NUM_BUS; b++) begin
        req[b]    = $urandom_range(0, 1);
        gnt[b]    = $urandom_range(0, 1);
        rvalid[b] = $urandom_range(0, 1);
        rready[b] = $urandom_range(0, 1);
      end
      pc_set     = ($urandom_range(0, 7) == 0);
      pc_mux     = obs_support_pkg::pc_mux_e'($urandom_range(0, 7));
      rvfi_valid = ($urandom_range(0, 3) == 0);
      step();
    end
  endtask

  // Data grant, then a trap of the given kind together with a request
  task automatic trap_with_request(input obs_support_pkg::pc_mux_e kind);
    retire();
    req[1] = 1'b1;
    gnt[1] = 1'b1;
    step();
    gnt[1] = 1'b0;
    pc_set = 1'b1;
    pc_mux = kind;
    step();
    drive_idle();
    step();
    step();
    retire();
    step();
  endtask

  // Optional bus-error trap, then a grant, then a request
  task automatic request_after_trap(input bit with_trap);
    retire();
    pc_set = with_trap;
    pc_mux = obs_support_pkg::PC_TRAP_DBE;
    step();
    drive_idle();
    gnt[1] = 1'b1;
    step();
    gnt[1] = 1'b0;
    req[1] = 1'b1;
    step();
    drive_idle();
    step();
    step();
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    void'($urandom(SEED));
    rst_ni = 1'b1;
    drive_idle();
    // Reset goes low on the first falling edge, ahead of any rising edge
    step();
    rst_ni = 1'b0;
    repeat (RESET_CYCLES) step();
    rst_ni = 1'b1;
    close_test("reset");

    for (int b = 0; b < `OBS_NUM_BUS; b++) stall_address(b);
    close_test("address_stall");
    for (int b = 0; b < `OBS_NUM_BUS; b++) stall_response(b);
    close_test("response_stall");

    // Responses with nothing outstanding, then both phases at once
    rvalid = '1;
    rready = '1;
    step();
    req = '1;
    gnt = '1;
    step();
    run_traffic(TRAFFIC_CYCLES);
    close_test("outstanding_count");

    trap_with_request(obs_support_pkg::PC_TRAP_EXC);
    trap_with_request(obs_support_pkg::PC_TRAP_IRQ);
    trap_with_request(obs_support_pkg::PC_JUMP);
    close_test("trap_and_request");
    request_after_trap(1'b1);
    request_after_trap(1'b0);
    close_test("request_after_trap");

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the test budget
  initial begin
    #((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Error: run timed out after %0d cycles", TOTAL_CYCLES + MARGIN_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/obi_obs_if.sv
/*
  Observed strobes of one OBI bus
  Read-only modport for the trackers
*/

`timescale 1ns/100ps
`default_nettype none

interface obi_obs_if;

  // -------------------------------------------------------------------------
  // Address phase strobes
  // -------------------------------------------------------------------------
  // Request from the core
  logic req;
  // Grant from the slave
  logic gnt;

  // -------------------------------------------------------------------------
  // Response phase strobes
  // -------------------------------------------------------------------------
  // Response valid from the slave
  logic rvalid;
  // Response ready from the core, may stall
  logic rready;

  // Trackers only sample, nothing is driven back
  modport observer (
    input req,
    input gnt,
    input rvalid,
    input rready
  );

endinterface

`default_nettype wire

// File: logic/obi_phase_tracker.sv
/*
  Phase tracker for one OBI bus
  Continued address and response phase flags, outstanding address-phase count
*/

`timescale 1ns/100ps
`default_nettype none

`include "obs_support_defines.svh"

module obi_phase_tracker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  obi_obs_if.observer           bus_i,
  output logic                  addr_ph_cont_o,
  output logic                  resp_ph_cont_o,
  output logic [`OBS_CNT_W-1:0] addr_ph_cnt_o
);

  // -------------------------------------------------------------------------
  // Phase completion
  // -------------------------------------------------------------------------
  // Address phase ends on req with gnt
  logic addr_ph_done;
  // Response phase ends on rvalid with rready
  logic resp_ph_done;

  assign addr_ph_done = bus_i.req & bus_i.gnt;
  assign resp_ph_done = bus_i.rvalid & bus_i.rready;

  // -------------------------------------------------------------------------
  // Continued phase flags
  // -------------------------------------------------------------------------
  // Address flag high when req waits for gnt
  // Response flag high when rvalid waits for rready
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_ph_cont_o <= 1'b0;
      resp_ph_cont_o <= 1'b0;
    end else begin
      addr_ph_cont_o <= bus_i.req & ~bus_i.gnt;
      resp_ph_cont_o <= bus_i.rvalid & ~bus_i.rready;
    end
  end

  // -------------------------------------------------------------------------
  // Outstanding address-phase count
  // -------------------------------------------------------------------------
  // Count is zero, blocks a decrement
  logic cnt_empty;

  assign cnt_empty = (addr_ph_cnt_o == '0);

  // Both phases in one cycle cancel out
  // A response with nothing outstanding leaves the count at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_ph_cnt_o <= '0;
    end else begin
      if (addr_ph_done && !resp_ph_done) begin
        // New address phase waiting for its response
        addr_ph_cnt_o <= addr_ph_cnt_o + 1'b1;
      end else if (!addr_ph_done && resp_ph_done && !cnt_empty) begin
        // One outstanding phase answered
        addr_ph_cnt_o <= addr_ph_cnt_o - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/obs_support_defines.svh
/*
  Build-time sizes for the bus observer:
  outstanding address-phase count width and number of watched buses
*/

`ifndef OBS_SUPPORT_DEFINES_SVH
`define OBS_SUPPORT_DEFINES_SVH

// ---------------------------------------------------------------------------
// Counter sizing
// ---------------------------------------------------------------------------
// Width of the outstanding address-phase count
`define OBS_CNT_W 8

// ---------------------------------------------------------------------------
// Bus sizing
// ---------------------------------------------------------------------------
// Instruction fetch bus and data bus
`define OBS_NUM_BUS 2

`endif

// File: logic/obs_support_pkg.sv
/*
  Shared types for the bus observer:
  program-counter source encoding and controller status struct
*/

`default_nettype none

package obs_support_pkg;

  // -------------------------------------------------------------------------
  // Program-counter source, as chosen by the controller
  // -------------------------------------------------------------------------
  // Exception traps are PC_TRAP_EXC and PC_TRAP_DBE
  // PC_TRAP_IRQ is an interrupt and does not count as one
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_TRAP_EXC = 3'd3,
    PC_TRAP_IRQ = 3'd4,
    PC_TRAP_DBE = 3'd5,
    PC_TRAP_DBD = 3'd6,
    PC_DRET     = 3'd7
  } pc_mux_e;

  // -------------------------------------------------------------------------
  // Controller status seen in writeback
  // -------------------------------------------------------------------------
  // 4 bits, pc_set in the top bit
  typedef struct packed {
    // New PC is being loaded this cycle
    logic    pc_set;
    // Source of that PC
    pc_mux_e pc_mux;
  } ctrl_fsm_t;

endpackage

`default_nettype wire

// File: logic/obs_support_top.sv
/*
  Observer top level
  Instruction and data bus phase trackers plus trap request tracker
*/

`timescale 1ns/100ps
`default_nettype none

`include "obs_support_defines.svh"

module obs_support_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Instruction fetch bus
  input  logic                      instr_req_i,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  input  logic                      instr_rready_i,
  // Data bus
  input  logic                      data_req_i,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  input  logic                      data_rready_i,
  // Controller status and retirement
  input  logic                      ctrl_pc_set_i,
  input  obs_support_pkg::pc_mux_e  ctrl_pc_mux_i,
  input  logic                      rvfi_valid_i,
  // Indicators
  output logic                      instr_addr_ph_cont_o,
  output logic                      instr_resp_ph_cont_o,
  output logic [`OBS_CNT_W-1:0]     instr_addr_ph_cnt_o,
  output logic                      data_addr_ph_cont_o,
  output logic                      data_resp_ph_cont_o,
  output logic [`OBS_CNT_W-1:0]     data_addr_ph_cnt_o,
  output logic                      req_after_exc_o
);

  // -------------------------------------------------------------------------
  // Per-bus strobes, bit 0 instruction, bit 1 data
  // -------------------------------------------------------------------------
  logic [`OBS_NUM_BUS-1:0] bus_req;
  logic [`OBS_NUM_BUS-1:0] bus_gnt;
  logic [`OBS_NUM_BUS-1:0] bus_rvalid;
  logic [`OBS_NUM_BUS-1:0] bus_rready;

  assign bus_req    = {data_req_i, instr_req_i};
  assign bus_gnt    = {data_gnt_i, instr_gnt_i};
  assign bus_rvalid = {data_rvalid_i, instr_rvalid_i};
  assign bus_rready = {data_rready_i, instr_rready_i};

  obi_obs_if u_instr_if ();
  obi_obs_if u_data_if ();

  assign u_instr_if.req    = bus_req[0];
  assign u_instr_if.gnt    = bus_gnt[0];
  assign u_instr_if.rvalid = bus_rvalid[0];
  assign u_instr_if.rready = bus_rready[0];

  assign u_data_if.req     = bus_req[1];
  assign u_data_if.gnt     = bus_gnt[1];
  assign u_data_if.rvalid  = bus_rvalid[1];
  assign u_data_if.rready  = bus_rready[1];

  // -------------------------------------------------------------------------
  // Phase trackers
  // -------------------------------------------------------------------------
  obi_phase_tracker u_instr_trk (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .bus_i          (u_instr_if),
    .addr_ph_cont_o (instr_addr_ph_cont_o),
    .resp_ph_cont_o (instr_resp_ph_cont_o),
    .addr_ph_cnt_o  (instr_addr_ph_cnt_o)
  );

  obi_phase_tracker u_data_trk (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .bus_i          (u_data_if),
    .addr_ph_cont_o (data_addr_ph_cont_o),
    .resp_ph_cont_o (data_resp_ph_cont_o),
    .addr_ph_cnt_o  (data_addr_ph_cnt_o)
  );

  // -------------------------------------------------------------------------
  // Trap tracking on the data bus
  // -------------------------------------------------------------------------
  // Controller status packed as writeback presents it
  obs_support_pkg::ctrl_fsm_t ctrl_fsm;

  assign ctrl_fsm.pc_set = ctrl_pc_set_i;
  assign ctrl_fsm.pc_mux = ctrl_pc_mux_i;

  trap_req_tracker u_trap_trk (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ctrl_fsm_i      (ctrl_fsm),
    .rvfi_valid_i    (rvfi_valid_i),
    .data_bus_i      (u_data_if),
    .req_after_exc_o (req_after_exc_o)
  );

endmodule

`default_nettype wire

// File: logic/trap_req_tracker.sv
/*
  Trap entry tracker
  Flags data requests issued after an exception trap, before the next retirement
*/

`timescale 1ns/100ps
`default_nettype none

module trap_req_tracker (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  obs_support_pkg::ctrl_fsm_t  ctrl_fsm_i,
  input  logic                        rvfi_valid_i,
  obi_obs_if.observer                 data_bus_i,
  output logic                        req_after_exc_o
);

  // -------------------------------------------------------------------------
  // Trap decode
  // -------------------------------------------------------------------------
  // Exception or bus-error trap taken in writeback
  logic exc_trap;

  // Interrupts and jumps are not counted
  assign exc_trap = ctrl_fsm_i.pc_set &&
                    ((ctrl_fsm_i.pc_mux == obs_support_pkg::PC_TRAP_EXC) ||
                     (ctrl_fsm_i.pc_mux == obs_support_pkg::PC_TRAP_DBE));

  // -------------------------------------------------------------------------
  // Tracking state
  // -------------------------------------------------------------------------
  // Data grant from the previous cycle
  logic gnt_q;
  // Trap taken, no retirement since
  logic exception_active;
  // New data request with a grant seen last cycle
  logic req_with_gnt_q;

  assign req_with_gnt_q = data_bus_i.req & gnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q            <= 1'b0;
      exception_active <= 1'b0;
      req_after_exc_o  <= 1'b0;
    end else begin
      gnt_q <= data_bus_i.gnt;

      if (exc_trap) begin
        // Trap wins over a retirement in the same cycle
        exception_active <= 1'b1;
        if (req_with_gnt_q) begin
          req_after_exc_o <= 1'b1;
        end
      end else if (rvfi_valid_i) begin
        // Next instruction retired, window closed
        exception_active <= 1'b0;
        req_after_exc_o  <= 1'b0;
      end else if (exception_active && req_with_gnt_q) begin
        req_after_exc_o <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: obs_support_top.f
+incdir+logic
logic/obs_support_pkg.sv
logic/obi_obs_if.sv
logic/obi_phase_tracker.sv
logic/trap_req_tracker.sv
logic/obs_support_top.sv
dv/tb_obs_support.sv
